/* hw/cpuPkg.sv */
/*
 * Shared types and constants for the 16-bit three-stage core.
 * Widths are fixed by the ISA and the core has no parameters.
 * ALU ops whose destination is r0 are architectural no-ops: no write, no flags.
 * Opcodes outside the ALU, immediate and branch groups are no-ops.
 */
`default_nettype none

package cpuPkg;

	// Data, instruction and address widths
	typedef logic [15:0] word_t;
	typedef logic [23:0] instr_t;
	typedef logic [3:0]  regAddr_t;
	typedef logic [7:0]  imemAddr_t;

	// Condition flags, N on top
	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	// Opcode field, instr[23:19]
	typedef enum logic [4:0] {
		OP_ADD    = 5'd0,
		OP_SUB    = 5'd1,
		OP_AND    = 5'd2,
		OP_OR     = 5'd3,
		OP_XOR    = 5'd4,
		OP_SLL    = 5'd5,
		OP_SRL    = 5'd6,
		OP_BRANCH = 5'd7,
		OP_IMML   = 5'd8,
		OP_IMMH   = 5'd9
	} opcode_t;

	// Branch condition field, instr[2:0]
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_VS = 3'd6,
		COND_AL = 3'd7
	} cond_t;

	// Decode to execute payload
	typedef struct packed {
		opcode_t  opcode;
		regAddr_t dest;
		word_t    opA;
		word_t    opB;
	} decoded_t;

	// Writeback, forwarding and retirement
	typedef struct packed {
		logic     valid;
		regAddr_t addr;
		word_t    data;
	} wb_t;

	localparam regAddr_t STATUS_REG = 4'd15;

	// AND r0, r0, r0 with every other field zero
	localparam instr_t NOP_INSTR = 24'h10_0000;

	// Bit positions inside r15
	localparam int CCD_DONE_BIT  = 0;
	localparam int CCD_EN_BIT    = 1;
	localparam int ACC_DONE_BIT  = 2;
	localparam int ACC_EN_BIT    = 3;
	localparam int ACC_START_BIT = 4;

endpackage

`default_nettype wire

/* hw/condEval.sv */
/*
 * Branch decision from condition code and forwarded flags.
 * Purely combinational; taken is low whenever isBranch is low.
 */
`timescale 1ns/1ps
`default_nettype none

module condEval import cpuPkg::*; (
	input  logic   isBranch,
	input  cond_t  cond,
	input  flags_t flags,
	output logic   taken
);

	logic condTrue;

	always_comb begin
		case (cond)
			COND_NE: condTrue = !flags.z;
			COND_EQ: condTrue = flags.z;
			// Strictly positive
			COND_GT: condTrue = !flags.z && !flags.n;
			COND_LT: condTrue = flags.n;
			COND_GE: condTrue = !flags.n;
			COND_LE: condTrue = flags.n || flags.z;
			// Signed overflow from the last ADD/SUB
			COND_VS: condTrue = flags.v;
			default: condTrue = 1'b1;
		endcase
	end

	assign taken = isBranch && condTrue;

endmodule

`default_nettype wire

/* hw/fetchDecode.sv */
/*
 * Combined fetch/decode stage.
 * Instruction memory has one cycle of read latency; imemAddr is combinational.
 * PC holds the address of the instruction now in decode and resets to all ones.
 * Branches resolve here on flags forwarded from execute, with no bubble.
 * r15 is never forwarded here; the status block bypasses its own writes.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchDecode import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      halt,
	input  instr_t    instr,
	input  flags_t    flagsFwd,
	input  wb_t       wbFwd,
	output regAddr_t  rdAddr1,
	output regAddr_t  rdAddr2,
	input  word_t     rdData1,
	input  word_t     rdData2,
	output imemAddr_t imemAddr,
	output decoded_t  dec
);

	imemAddr_t pc;
	imemAddr_t nextPc;
	imemAddr_t target;
	logic      fetchValid;
	instr_t    curInstr;
	opcode_t   opcode;
	regAddr_t  dest;
	regAddr_t  src1;
	regAddr_t  src2;
	logic [7:0] imm;
	cond_t     cond;
	logic      isBranch;
	logic      taken;
	word_t     src1Data;
	word_t     src2Data;
	word_t     opB;

	// First cycle after reset has nothing fetched yet
	assign curInstr = (halt || !fetchValid) ? NOP_INSTR : instr;

	// Field split
	assign opcode = opcode_t'(curInstr[23:19]);
	assign dest   = curInstr[18:15];
	assign src1   = curInstr[14:11];
	assign src2   = curInstr[10:7];
	assign imm    = curInstr[10:3];
	assign cond   = cond_t'(curInstr[2:0]);

	assign isBranch = (opcode == OP_BRANCH);

	condEval uCond (
		.isBranch(isBranch),
		.cond    (cond),
		.flags   (flagsFwd),
		.taken   (taken)
	);

	// Sign extension drops out at 8 address bits
	assign target = pc + imm + imemAddr_t'(1);
	assign nextPc = taken ? target : pc + imemAddr_t'(1);

	// Halt refetches the held instruction
	assign imemAddr = halt ? pc : nextPc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= '1;
			fetchValid <= 1'b0;
		end else if (!halt) begin
			pc         <= nextPc;
			fetchValid <= 1'b1;
		end
	end

	// Operand read
	assign rdAddr1 = src1;
	assign rdAddr2 = src2;

	// Result of the instruction in execute is not in the file yet
	always_comb begin
		src1Data = rdData1;
		src2Data = rdData2;
		if (wbFwd.valid && wbFwd.addr != STATUS_REG) begin
			if (wbFwd.addr == src1)
				src1Data = wbFwd.data;
			if (wbFwd.addr == src2)
				src2Data = wbFwd.data;
		end
	end

	// Immediates replace source 2
	always_comb begin
		case (opcode)
			OP_IMML: opB = {8'h00, imm};
			OP_IMMH: opB = {imm, 8'h00};
			default: opB = src2Data;
		endcase
	end

	// Decode register, reset to the bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec <= '{opcode: OP_AND, dest: '0, opA: '0, opB: '0};
		end else begin
			dec.opcode <= opcode;
			dec.dest   <= dest;
			dec.opA    <= src1Data;
			dec.opB    <= opB;
		end
	end

endmodule

`default_nettype wire

/* hw/regFile.sv */
/*
 * General purpose registers r1 to r14 with two combinational read ports.
 * r0 reads as zero and ignores writes.
 * r15 is not stored here; reads and writes go to the status block.
 * Writes land at the clock edge that ends the writeback cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  regAddr_t rdAddr1,
	input  regAddr_t rdAddr2,
	output word_t    rdData1,
	output word_t    rdData2,
	input  wb_t      wb,
	input  word_t    statusRd,
	output logic     statusWe,
	output word_t    statusWd
);

	word_t regs [1:14];
	logic  gprWe;

	// Split writeback between storage and r15
	assign gprWe    = wb.valid && (wb.addr != '0) && (wb.addr != STATUS_REG);
	assign statusWe = wb.valid && (wb.addr == STATUS_REG);
	assign statusWd = wb.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (gprWe)
			regs[wb.addr] <= wb.data;
	end

	// Read ports
	assign rdData1 = (rdAddr1 == '0)         ? '0 :
	                 (rdAddr1 == STATUS_REG) ? statusRd : regs[rdAddr1];
	assign rdData2 = (rdAddr2 == '0)         ? '0 :
	                 (rdAddr2 == STATUS_REG) ? statusRd : regs[rdAddr2];

endmodule

`default_nettype wire

/* hw/statusReg.sv */
/*
 * Control/status register r15 for the CCD and accelerator.
 * Bits 1, 3 and 4 are writable and drive the enables; bits 0 and 2 follow
 * the done inputs one cycle late. All other bits read as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module statusReg import cpuPkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  statusWe,
	input  word_t statusWd,
	output word_t statusRd,
	input  logic  ccdDone,
	input  logic  accDone,
	output logic  ccdEn,
	output logic  accEn,
	output logic  accStart
);

	logic ccdEnQ, accEnQ, accStartQ;
	logic ccdDoneQ, accDoneQ;
	logic ccdEnNext, accEnNext, accStartNext;

	// Pending write, also seen by the read port
	assign ccdEnNext    = statusWe ? statusWd[CCD_EN_BIT]    : ccdEnQ;
	assign accEnNext    = statusWe ? statusWd[ACC_EN_BIT]    : accEnQ;
	assign accStartNext = statusWe ? statusWd[ACC_START_BIT] : accStartQ;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ccdEnQ    <= 1'b0;
			accEnQ    <= 1'b0;
			accStartQ <= 1'b0;
			ccdDoneQ  <= 1'b0;
			accDoneQ  <= 1'b0;
		end else begin
			ccdEnQ    <= ccdEnNext;
			accEnQ    <= accEnNext;
			accStartQ <= accStartNext;
			// Done bits sampled every cycle
			ccdDoneQ  <= ccdDone;
			accDoneQ  <= accDone;
		end
	end

	always_comb begin
		statusRd                = '0;
		statusRd[CCD_DONE_BIT]  = ccdDoneQ;
		statusRd[CCD_EN_BIT]    = ccdEnNext;
		statusRd[ACC_DONE_BIT]  = accDoneQ;
		statusRd[ACC_EN_BIT]    = accEnNext;
		statusRd[ACC_START_BIT] = accStartNext;
	end

	// Outputs straight from the flops
	assign ccdEn    = ccdEnQ;
	assign accEn    = accEnQ;
	assign accStart = accStartQ;

endmodule

`default_nettype wire

/* hw/execUnit.sv */
/*
 * Execute stage: ALU, flag register and the writeback result.
 * wb and flagsFwd are combinational from the decode register.
 * Shifts are logical and use opB[3:0]. V is set only by ADD and SUB.
 * ALU ops into r0, branches and reserved opcodes leave the flags alone.
 */
`timescale 1ns/1ps
`default_nettype none

module execUnit import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  decoded_t dec,
	output wb_t      wb,
	output flags_t   flagsFwd
);

	word_t  result;
	logic   overflow;
	logic   isAlu;
	logic   isImm;
	logic   hasDest;
	logic   setsFlags;
	flags_t aluFlags;
	flags_t flagsQ;

	always_comb begin
		result   = dec.opB;
		overflow = 1'b0;
		case (dec.opcode)
			OP_ADD: begin
				result   = dec.opA + dec.opB;
				// Same operand signs, different result sign
				overflow = (dec.opA[15] == dec.opB[15]) && (result[15] != dec.opA[15]);
			end
			OP_SUB: begin
				result   = dec.opA - dec.opB;
				overflow = (dec.opA[15] != dec.opB[15]) && (result[15] != dec.opA[15]);
			end
			OP_AND: result = dec.opA & dec.opB;
			OP_OR:  result = dec.opA | dec.opB;
			OP_XOR: result = dec.opA ^ dec.opB;
			OP_SLL: result = dec.opA << dec.opB[3:0];
			OP_SRL: result = dec.opA >> dec.opB[3:0];
			// IMML/IMMH arrive already placed in opB
			default: result = dec.opB;
		endcase
	end

	assign isAlu   = dec.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
	assign isImm   = dec.opcode inside {OP_IMML, OP_IMMH};
	assign hasDest = (dec.dest != '0);

	// Bubbles are AND into r0 and must not disturb the flags
	assign setsFlags = isAlu && hasDest;

	assign aluFlags = '{n: result[15], v: overflow, z: (result == '0)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flagsQ <= '0;
		else if (setsFlags)
			flagsQ <= aluFlags;
	end

	// Flags as they stand after this instruction
	assign flagsFwd = setsFlags ? aluFlags : flagsQ;

	// Writeback and forwarding result
	assign wb.valid = (isAlu || isImm) && hasDest;
	assign wb.addr  = dec.dest;
	assign wb.data  = result;

endmodule

`default_nettype wire

/* hw/cpuTop.sv */
/*
 * Three-stage 16-bit core: fetch/decode, execute, writeback.
 * Instruction memory is external with one cycle of read latency.
 * wb doubles as the retirement port; halt freezes fetch and bubbles execute.
 * No data memory or debug bus.
 */
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      halt,
	input  instr_t    instr,
	output imemAddr_t imemAddr,
	input  logic      ccdDone,
	input  logic      accDone,
	output logic      ccdEn,
	output logic      accEn,
	output logic      accStart,
	output wb_t       wb
);

	decoded_t dec;
	flags_t   flagsFwd;
	regAddr_t rdAddr1;
	regAddr_t rdAddr2;
	word_t    rdData1;
	word_t    rdData2;
	word_t    statusRd;
	logic     statusWe;
	word_t    statusWd;

	fetchDecode uFetch (
		.clk     (clk),
		.rst_n   (rst_n),
		.halt    (halt),
		.instr   (instr),
		.flagsFwd(flagsFwd),
		.wbFwd   (wb),
		.rdAddr1 (rdAddr1),
		.rdAddr2 (rdAddr2),
		.rdData1 (rdData1),
		.rdData2 (rdData2),
		.imemAddr(imemAddr),
		.dec     (dec)
	);

	execUnit uExec (
		.clk     (clk),
		.rst_n   (rst_n),
		.dec     (dec),
		.wb      (wb),
		.flagsFwd(flagsFwd)
	);

	regFile uRegs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rdAddr1 (rdAddr1),
		.rdAddr2 (rdAddr2),
		.rdData1 (rdData1),
		.rdData2 (rdData2),
		.wb      (wb),
		.statusRd(statusRd),
		.statusWe(statusWe),
		.statusWd(statusWd)
	);

	statusReg uStatus (
		.clk     (clk),
		.rst_n   (rst_n),
		.statusWe(statusWe),
		.statusWd(statusWd),
		.statusRd(statusRd),
		.ccdDone (ccdDone),
		.accDone (accDone),
		.ccdEn   (ccdEn),
		.accEn   (accEn),
		.accStart(accStart)
	);

endmodule

`default_nettype wire

/* sim/cpuTop_chk.sv */
/*
 * Concurrent checks bound into cpuTop, sampled on the rising edge.
 * Disabled while reset is asserted.
 * failCount is read by the testbench for its summary.
 */
`timescale 1ns/1ps
`default_nettype none

module cpuTopChk import cpuPkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      halt,
	input imemAddr_t imemAddr,
	input wb_t       wb
);

	int failCount = 0;

	// r0 never retires
	noR0Write: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> wb.addr != '0)
	else begin
		$error("wb valid with destination r0");
		failCount++;
	end

	// Halt bubbles execute one cycle later
	noWbAfterHalt: assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> !wb.valid)
	else begin
		$error("wb valid in the cycle after halt");
		failCount++;
	end

	// Held PC keeps refetching the same word
	addrHeldInHalt: assert property (@(posedge clk) disable iff (!rst_n)
		(halt && $past(halt)) |-> $stable(imemAddr))
	else begin
		$error("imemAddr moved while halt was held");
		failCount++;
	end

endmodule

bind cpuTop cpuTopChk uChk (
	.clk     (clk),
	.rst_n   (rst_n),
	.halt    (halt),
	.imemAddr(imemAddr),
	.wb      (wb)
);

`default_nettype wire

/* include/isaModel.svh */
/*
 * Instruction-level model of the core, included inside the testbench module.
 * Runs the program in order from address 0; pipelining and halts are invisible.
 * ALU ops and immediates into r0 are skipped and leave the flags alone.
 * r15 reads return the model's enable bits and the done values passed in.
 */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

	// Program shared with the instruction memory answer
	instr_t    imem [0:255];
	word_t     mRegs [1:14];
	flags_t    mFlags;
	imemAddr_t mPc;
	logic      mCcdEn;
	logic      mAccEn;
	logic      mAccStart;

	task automatic modelReset();
		mRegs     = '{default: '0};
		mFlags    = '0;
		mPc       = '0;
		mCcdEn    = 1'b0;
		mAccEn    = 1'b0;
		mAccStart = 1'b0;
	endtask

	function automatic word_t modelRead(regAddr_t a, logic ccdDoneIn, logic accDoneIn);
		word_t v;
		v = '0;
		if (a == STATUS_REG) begin
			v[CCD_DONE_BIT]  = ccdDoneIn;
			v[CCD_EN_BIT]    = mCcdEn;
			v[ACC_DONE_BIT]  = accDoneIn;
			v[ACC_EN_BIT]    = mAccEn;
			v[ACC_START_BIT] = mAccStart;
		end else if (a != '0) begin
			v = mRegs[a];
		end
		return v;
	endfunction

	// Codes in order NE EQ GT LT GE LE VS AL
	function automatic logic condHolds(logic [2:0] c, flags_t f);
		logic hold;
		case (c)
			3'd0: hold = !f.z;
			3'd1: hold = f.z;
			3'd2: hold = !f.z && !f.n;
			3'd3: hold = f.n;
			3'd4: hold = !f.n;
			3'd5: hold = f.n || f.z;
			3'd6: hold = f.v;
			default: hold = 1'b1;
		endcase
		return hold;
	endfunction

	// Steps until the next writing instruction and applies it
	task automatic modelStep(input logic ccdDoneIn, input logic accDoneIn,
			output regAddr_t addr, output word_t data, output logic found);
		instr_t   ins;
		logic [4:0] op;
		regAddr_t rd;
		word_t    a;
		word_t    b;
		word_t    r;
		logic     v;
		logic     isAlu;
		int       sum;
		int       steps;
		found = 1'b0;
		addr  = '0;
		data  = '0;
		for (steps = 0; steps < 256 && !found; steps++) begin
			ins   = imem[mPc];
			op    = ins[23:19];
			rd    = ins[18:15];
			a     = modelRead(ins[14:11], ccdDoneIn, accDoneIn);
			b     = modelRead(ins[10:7], ccdDoneIn, accDoneIn);
			isAlu = (op <= 5'd6);
			r     = '0;
			v     = 1'b0;
			mPc   = mPc + 8'd1;
			if (op == OP_BRANCH) begin
				// Target is branch address plus offset plus one
				if (condHolds(ins[2:0], mFlags))
					mPc = mPc + ins[10:3];
			end else if (isAlu && rd != '0) begin
				case (op)
					OP_ADD: begin
						sum = int'($signed(a)) + int'($signed(b));
						r   = word_t'(sum);
						v   = (sum > 32767) || (sum < -32768);
					end
					OP_SUB: begin
						sum = int'($signed(a)) - int'($signed(b));
						r   = word_t'(sum);
						v   = (sum > 32767) || (sum < -32768);
					end
					OP_AND: r = a & b;
					OP_OR:  r = a | b;
					OP_XOR: r = a ^ b;
					OP_SLL: r = a << b[3:0];
					default: r = a >> b[3:0];
				endcase
				mFlags.n = r[15];
				mFlags.v = v;
				mFlags.z = (r == '0);
				found    = 1'b1;
			end else if ((op == OP_IMML || op == OP_IMMH) && rd != '0) begin
				r     = (op == OP_IMML) ? {8'h00, ins[10:3]} : {ins[10:3], 8'h00};
				found = 1'b1;
			end
			if (found) begin
				if (rd == STATUS_REG) begin
					mCcdEn    = r[CCD_EN_BIT];
					mAccEn    = r[ACC_EN_BIT];
					mAccStart = r[ACC_START_BIT];
				end else begin
					mRegs[rd] = r;
				end
				addr = rd;
				data = r;
			end
		end
	endtask

`endif

/* sim/cpuTb.sv */
/*
 * Testbench for cpuTop running a random program from a 256-word memory.
 * The memory answers imemAddr one cycle later; inputs move 1 ns after the edge.
 * Done inputs change only inside halt windows of 3 or more cycles.
 * Assertion failures from the bound checker count toward the result.
 */
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int RETIRE_TARGET = 2000;
	// Eight cycles per retired result is far above the expected rate
	localparam int TIMEOUT_NS    = (RESET_CYCLES + RETIRE_TARGET * 8) * CLK_PERIOD;

	logic      clk;
	logic      rst_n;
	logic      halt;
	instr_t    instr;
	imemAddr_t imemAddr;
	logic      ccdDone;
	logic      accDone;
	logic      ccdEn;
	logic      accEn;
	logic      accStart;
	wb_t       wb;

	integer    seed;
	imemAddr_t fetchAddr;
	int        retired;
	int        mismatches;
	int        otherErrors;

	`include "isaModel.svh"

	cpuTop dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.halt    (halt),
		.instr   (instr),
		.imemAddr(imemAddr),
		.ccdDone (ccdDone),
		.accDone (accDone),
		.ccdEn   (ccdEn),
		.accEn   (accEn),
		.accStart(accStart),
		.wb      (wb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkFetch(input string name, input imemAddr_t got, input imemAddr_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	// Mix weighted toward writing instructions, forward branches only
	task automatic fillProgram();
		int     i;
		int     kind;
		instr_t ins;
		for (i = 0; i < 256; i++) begin
			kind = int'($unsigned($random(seed)) % 16);
			ins  = instr_t'($random(seed));
			if (kind < 9) begin
				ins[23:19] = 5'(kind % 7);
			end else if (kind < 11) begin
				ins[23:19] = OP_IMML;
			end else if (kind < 12) begin
				ins[23:19] = OP_IMMH;
			end else if (kind < 14) begin
				ins[23:19] = OP_BRANCH;
				// Offset 0 to 15
				ins[10:7]  = '0;
			end else begin
				ins[23:19] = 5'(10 + ($unsigned($random(seed)) % 22));
			end
			imem[i] = ins;
		end
	endtask

	// Halt for len cycles, new done values in the second one
	task automatic haltWindow(input int len);
		int i;
		halt = 1'b1;
		for (i = 1; i < len; i++) begin
			@(posedge clk);
			#1;
			if (i == 1 && len >= 3) begin
				ccdDone = 1'($random(seed));
				accDone = 1'($random(seed));
			end
		end
		@(posedge clk);
		#1;
		halt = 1'b0;
	endtask

	// Enables reflect writes retired before this cycle
	task automatic checkCycle();
		regAddr_t expAddr;
		word_t    expData;
		logic     found;
		checkBit("ccdEn", ccdEn, mCcdEn);
		checkBit("accEn", accEn, mAccEn);
		checkBit("accStart", accStart, mAccStart);
		if (wb.valid) begin
			modelStep(ccdDone, accDone, expAddr, expData, found);
			if (!found) begin
				$display("ERROR t=%0t: wb retired but the model has no writing instruction",
					$time);
				otherErrors++;
			end else begin
				checkAddr("wb.addr", wb.addr, expAddr);
				checkWord("wb.data", wb.data, expData);
			end
			retired++;
		end
	endtask

	// Instruction memory, one cycle of read latency
	always @(posedge clk) begin
		#1;
		instr = imem[fetchAddr];
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		fetchAddr = imemAddr;
		if (rst_n)
			checkCycle();
	end

	initial begin
		seed        = 32'h1244_c9df;
		rst_n       = 1'b0;
		halt        = 1'b0;
		instr       = NOP_INSTR;
		ccdDone     = 1'b0;
		accDone     = 1'b0;
		fetchAddr   = '0;
		retired     = 0;
		mismatches  = 0;
		otherErrors = 0;
		fillProgram();
		modelReset();

		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		checkBit("wb.valid", wb.valid, 1'b0);
		checkBit("ccdEn", ccdEn, 1'b0);
		checkBit("accEn", accEn, 1'b0);
		checkBit("accStart", accStart, 1'b0);
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		// First fetch after reset
		checkFetch("imemAddr", imemAddr, '0);

		while (retired < RETIRE_TARGET) begin
			@(posedge clk);
			#1;
			if ($unsigned($random(seed)) % 12 == 0)
				haltWindow(1 + int'($unsigned($random(seed)) % 5));
		end

		$display("Summary: %0d retired, %0d mismatches, %0d other errors, %0d assertion failures",
			retired, mismatches, otherErrors, dut.uChk.failCount);
		if (mismatches == 0 && otherErrors == 0 && dut.uChk.failCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: only %0d of %0d results retired after %0d ns",
			retired, RETIRE_TARGET, TIMEOUT_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
hw/cpuPkg.sv
hw/condEval.sv
hw/fetchDecode.sv
hw/regFile.sv
hw/statusReg.sv
hw/execUnit.sv
hw/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTb.sv

/* Makefile */
# Verilator lint, simulation and clean for the 16-bit core

VERILATOR ?= verilator
TOP       ?= cpuTb
RTL_TOP   ?= cpuTop
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

# RTL alone first, then the full testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Result comes from the log, not from the exit code of the binary
sim: build
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
